/* common/ooo_pkg.sv */
package ooo_pkg;

    localparam int data_w = 32;

    // Seven entries, addressed by tags 1 to 7. Tag 0 means the register file is current.
    localparam int rob_depth = 7;

    typedef logic [4:0] reg_addr_t;
    typedef logic [2:0] rob_tag_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
    } dispatch_req_t;

    // A source operand is either a value (ready) or the tag of its producer.
    typedef struct packed {
        logic              ready;
        logic [data_w-1:0] value;
        rob_tag_t          tag;
    } operand_t;

    typedef struct packed {
        rob_tag_t  tag;
        reg_addr_t rd;
        operand_t  op1;
        operand_t  op2;
    } dispatch_res_t;

    typedef struct packed {
        rob_tag_t          tag;
        logic [data_w-1:0] value;
    } complete_t;

    typedef struct packed {
        rob_tag_t          tag;
        reg_addr_t         rd;
        logic [data_w-1:0] value;
    } retire_t;

endpackage

/* regfile/reg_file.sv */
`timescale 1ns/1ns

module reg_file import ooo_pkg::*; #(
    parameter int num_regs = 32
) (
    input  logic              clk,
    input  logic              rst,

    input  reg_addr_t         rd_addr1,
    input  reg_addr_t         rd_addr2,
    output logic [data_w-1:0] rd_val1,
    output logic [data_w-1:0] rd_val2,
    output rob_tag_t          rd_tag1,
    output rob_tag_t          rd_tag2,

    input  logic              rename_en,
    input  reg_addr_t         rename_reg,
    input  rob_tag_t          rename_tag,

    input  logic              retire_en,
    input  retire_t           retire
);

    logic [data_w-1:0] regs [num_regs];
    rob_tag_t          tags [num_regs];

    logic ren_ok;
    logic ret_ok;

    // Register 0 is never written or renamed, so it keeps the zero from reset.
    assign ren_ok = rename_en && (rename_reg != '0) && (rename_reg < num_regs);
    assign ret_ok = retire_en && (retire.rd != '0) && (retire.rd < num_regs);

    // Lookups see the state from before the clock edge.
    always_comb begin
        rd_val1 = '0;
        rd_tag1 = '0;
        if (rd_addr1 < num_regs) begin
            rd_val1 = regs[rd_addr1];
            rd_tag1 = tags[rd_addr1];
        end
    end

    always_comb begin
        rd_val2 = '0;
        rd_tag2 = '0;
        if (rd_addr2 < num_regs) begin
            rd_val2 = regs[rd_addr2];
            rd_tag2 = tags[rd_addr2];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (ret_ok) begin
                regs[retire.rd] <= retire.value;
                // A later rename has already moved the producer on; keep that tag.
                if (tags[retire.rd] == retire.tag) begin
                    tags[retire.rd] <= '0;
                end
            end
            // Placed after the retire update so a rename on the same edge wins.
            if (ren_ok) begin
                tags[rename_reg] <= rename_tag;
            end
        end
    end

endmodule

/* rob/reorder_buffer.sv */
`timescale 1ns/1ns

module reorder_buffer import ooo_pkg::*; #(
    parameter int rob_entries = rob_depth
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              alloc,
    input  reg_addr_t         alloc_rd,
    output rob_tag_t          alloc_tag,
    output logic              full,

    input  logic              complete,
    input  complete_t         comp,

    input  rob_tag_t          look_tag1,
    input  rob_tag_t          look_tag2,
    output logic              look_ready1,
    output logic              look_ready2,
    output logic [data_w-1:0] look_val1,
    output logic [data_w-1:0] look_val2,

    output logic              retire_en,
    output retire_t           retire,
    output logic              retire_valid,
    output retire_t           ret
);

    reg_addr_t         ent_rd   [rob_entries];
    logic              ent_done [rob_entries];
    logic [data_w-1:0] ent_val  [rob_entries];

    logic [2:0] head;
    logic [2:0] tail;
    logic [2:0] count;
    logic       alloc_ok;

    function automatic logic [2:0] next_ptr(logic [2:0] p);
        return (p == 3'(rob_entries - 1)) ? 3'd0 : p + 3'd1;
    endfunction

    function automatic logic tag_in_range(rob_tag_t t);
        return (t != '0) && (t <= rob_entries);
    endfunction

    // Tags are the entry index plus one.
    assign alloc_tag = rob_tag_t'(tail + 3'd1);
    assign full      = (count == 3'(rob_entries));
    assign alloc_ok  = alloc && !full;

    // Forwarding answers use the done flags from before the edge.
    always_comb begin
        look_ready1 = 1'b0;
        look_val1   = '0;
        if (tag_in_range(look_tag1)) begin
            look_ready1 = ent_done[look_tag1 - 3'd1];
            look_val1   = ent_val[look_tag1 - 3'd1];
        end
    end

    always_comb begin
        look_ready2 = 1'b0;
        look_val2   = '0;
        if (tag_in_range(look_tag2)) begin
            look_ready2 = ent_done[look_tag2 - 3'd1];
            look_val2   = ent_val[look_tag2 - 3'd1];
        end
    end

    // The head retires into the register file as soon as it is done.
    assign retire_en    = (count != '0) && ent_done[head];
    assign retire.tag   = rob_tag_t'(head + 3'd1);
    assign retire.rd    = ent_rd[head];
    assign retire.value = ent_val[head];

    always_ff @(posedge clk) begin
        if (!rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_entries; i++) begin
                ent_done[i] <= 1'b0;
            end
        end else begin
            if (alloc_ok) begin
                ent_rd[tail]   <= alloc_rd;
                ent_done[tail] <= 1'b0;
                tail           <= next_ptr(tail);
            end
            if (complete && tag_in_range(comp.tag)) begin
                ent_done[comp.tag - 3'd1] <= 1'b1;
                ent_val[comp.tag - 3'd1]  <= comp.value;
            end
            if (retire_en) begin
                ent_done[head] <= 1'b0;
                head           <= next_ptr(head);
            end
            case ({alloc_ok, retire_en})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;
            endcase
        end
    end

    // Retirement seen from outside, one cycle after the register file write.
    always_ff @(posedge clk) begin
        if (!rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= retire_en;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_en) begin
            ret <= retire;
        end
    end

endmodule

/* hdl/dispatch_unit.sv */
`timescale 1ns/1ns

module dispatch_unit import ooo_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              dispatch,
    input  dispatch_req_t     disp_req,
    input  logic              full,
    input  rob_tag_t          alloc_tag,

    output reg_addr_t         src_addr1,
    output reg_addr_t         src_addr2,
    input  logic [data_w-1:0] rf_val1,
    input  logic [data_w-1:0] rf_val2,
    input  rob_tag_t          rf_tag1,
    input  rob_tag_t          rf_tag2,

    input  logic              look_ready1,
    input  logic              look_ready2,
    input  logic [data_w-1:0] look_val1,
    input  logic [data_w-1:0] look_val2,

    output logic              alloc,
    output logic              rename_en,
    output reg_addr_t         rename_reg,

    output logic              disp_valid,
    output dispatch_res_t     disp_res
);

    operand_t op1;
    operand_t op2;

    // Tag 0 takes the register file value, a finished producer is forwarded,
    // anything else waits on its tag.
    function automatic operand_t resolve(
        rob_tag_t          tag,
        logic [data_w-1:0] rf_val,
        logic              fwd_ready,
        logic [data_w-1:0] fwd_val
    );
        operand_t op;
        op = '0;
        if (tag == '0) begin
            op.ready = 1'b1;
            op.value = rf_val;
        end else if (fwd_ready) begin
            op.ready = 1'b1;
            op.value = fwd_val;
        end else begin
            op.tag = tag;
        end
        return op;
    endfunction

    assign src_addr1  = disp_req.rs1;
    assign src_addr2  = disp_req.rs2;

    // A strobe while full is dropped.
    assign alloc      = dispatch && !full;
    assign rename_en  = alloc && (disp_req.rd != '0);
    assign rename_reg = disp_req.rd;

    assign op1 = resolve(rf_tag1, rf_val1, look_ready1, look_val1);
    assign op2 = resolve(rf_tag2, rf_val2, look_ready2, look_val2);

    always_ff @(posedge clk) begin
        if (!rst) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= alloc;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            disp_res.tag <= alloc_tag;
            disp_res.rd  <= disp_req.rd;
            disp_res.op1 <= op1;
            disp_res.op2 <= op2;
        end
    end

endmodule

/* hdl/ooo_front_top.sv */
`timescale 1ns/1ns

module ooo_front_top import ooo_pkg::*; #(
    parameter int num_regs    = 32,
    parameter int rob_entries = rob_depth
) (
    input  logic          clk,
    input  logic          rst,

    input  logic          dispatch,
    input  dispatch_req_t disp_req,
    input  logic          complete,
    input  complete_t     comp,

    output logic          full,
    output logic          disp_valid,
    output dispatch_res_t disp_res,
    output logic          retire_valid,
    output retire_t       ret
);

    reg_addr_t         src_addr1;
    reg_addr_t         src_addr2;
    logic [data_w-1:0] rf_val1;
    logic [data_w-1:0] rf_val2;
    rob_tag_t          rf_tag1;
    rob_tag_t          rf_tag2;
    logic              look_ready1;
    logic              look_ready2;
    logic [data_w-1:0] look_val1;
    logic [data_w-1:0] look_val2;
    logic              alloc;
    rob_tag_t          alloc_tag;
    logic              rename_en;
    reg_addr_t         rename_reg;
    logic              retire_en;
    retire_t           retire;

    reg_file #(
        .num_regs (num_regs)
    ) i_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rd_addr1   (src_addr1),
        .rd_addr2   (src_addr2),
        .rd_val1    (rf_val1),
        .rd_val2    (rf_val2),
        .rd_tag1    (rf_tag1),
        .rd_tag2    (rf_tag2),
        .rename_en  (rename_en),
        .rename_reg (rename_reg),
        .rename_tag (alloc_tag),
        .retire_en  (retire_en),
        .retire     (retire)
    );

    // The producer tags from the register file double as the forwarding lookups.
    reorder_buffer #(
        .rob_entries (rob_entries)
    ) i_reorder_buffer (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .alloc_rd     (disp_req.rd),
        .alloc_tag    (alloc_tag),
        .full         (full),
        .complete     (complete),
        .comp         (comp),
        .look_tag1    (rf_tag1),
        .look_tag2    (rf_tag2),
        .look_ready1  (look_ready1),
        .look_ready2  (look_ready2),
        .look_val1    (look_val1),
        .look_val2    (look_val2),
        .retire_en    (retire_en),
        .retire       (retire),
        .retire_valid (retire_valid),
        .ret          (ret)
    );

    dispatch_unit i_dispatch_unit (
        .clk         (clk),
        .rst         (rst),
        .dispatch    (dispatch),
        .disp_req    (disp_req),
        .full        (full),
        .alloc_tag   (alloc_tag),
        .src_addr1   (src_addr1),
        .src_addr2   (src_addr2),
        .rf_val1     (rf_val1),
        .rf_val2     (rf_val2),
        .rf_tag1     (rf_tag1),
        .rf_tag2     (rf_tag2),
        .look_ready1 (look_ready1),
        .look_ready2 (look_ready2),
        .look_val1   (look_val1),
        .look_val2   (look_val2),
        .alloc       (alloc),
        .rename_en   (rename_en),
        .rename_reg  (rename_reg),
        .disp_valid  (disp_valid),
        .disp_res    (disp_res)
    );

endmodule

/* test/ooo_ref_model.svh */
`ifndef OOO_REF_MODEL_SVH
`define OOO_REF_MODEL_SVH

// Mirror of the registers, the producer tags and the reorder buffer.
// Each step works on the state from before the clock edge.
logic [data_w-1:0] m_regs [32];
rob_tag_t          m_tags [32];
reg_addr_t         m_rd   [rob_depth];
logic              m_done [rob_depth];
logic [data_w-1:0] m_val  [rob_depth];
int                m_head;
int                m_tail;
int                m_count;

dispatch_res_t exp_disp [$];
retire_t       exp_ret  [$];

function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
        m_regs[i] = '0;
        m_tags[i] = '0;
    end
    for (int i = 0; i < rob_depth; i++) begin
        m_done[i] = 1'b0;
    end
    m_head  = 0;
    m_tail  = 0;
    m_count = 0;
endfunction

function automatic operand_t ref_operand(reg_addr_t r);
    operand_t op;
    rob_tag_t t;
    op = '0;
    t  = m_tags[r];
    if (t == 3'd0) begin
        op.ready = 1'b1;
        op.value = m_regs[r];
    end else if (m_done[t - 1]) begin
        op.ready = 1'b1;
        op.value = m_val[t - 1];
    end else begin
        op.tag = t;
    end
    return op;
endfunction

// One clock edge: queue the expected outputs, then apply the updates.
function automatic void model_step(logic disp, dispatch_req_t req, logic cmp, complete_t c);
    dispatch_res_t d;
    retire_t       r;
    logic          take;
    logic          retiring;
    take     = disp && (m_count < rob_depth);
    retiring = (m_count > 0) && m_done[m_head];
    if (take) begin
        d.tag = rob_tag_t'(m_tail + 1);
        d.rd  = req.rd;
        d.op1 = ref_operand(req.rs1);
        d.op2 = ref_operand(req.rs2);
        exp_disp.push_back(d);
    end
    if (retiring) begin
        r.tag   = rob_tag_t'(m_head + 1);
        r.rd    = m_rd[m_head];
        r.value = m_val[m_head];
        exp_ret.push_back(r);
        if (r.rd != 5'd0) begin
            m_regs[r.rd] = r.value;
            if (m_tags[r.rd] == r.tag) begin
                m_tags[r.rd] = '0;
            end
        end
        m_done[m_head] = 1'b0;
        m_head  = (m_head + 1) % rob_depth;
        m_count = m_count - 1;
    end
    if (cmp) begin
        m_done[c.tag - 1] = 1'b1;
        m_val[c.tag - 1]  = c.value;
    end
    // The rename comes last, so it wins over a retirement of the same register.
    if (take) begin
        m_rd[m_tail]   = req.rd;
        m_done[m_tail] = 1'b0;
        if (req.rd != 5'd0) begin
            m_tags[req.rd] = rob_tag_t'(m_tail + 1);
        end
        m_tail  = (m_tail + 1) % rob_depth;
        m_count = m_count + 1;
    end
endfunction

`endif

/* test/tb_ooo_front.sv */
`timescale 1ns/1ns

module tb_ooo_front import ooo_pkg::*; ();

    localparam int num_ops = 1500;
    // Each operation takes one cycle. The limit leaves ample room for the directed
    // phases and the drain.
    localparam int timeout_cycles = num_ops * 8 / 3;

    logic          clk = 1'b0;
    logic          rst;
    logic          dispatch;
    dispatch_req_t disp_req;
    logic          complete;
    complete_t     comp;
    logic          full;
    logic          disp_valid;
    dispatch_res_t disp_res;
    logic          retire_valid;
    retire_t       ret;
    int            cycles = 0;

    `include "ooo_ref_model.svh"

    ooo_front_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .disp_req     (disp_req),
        .complete     (complete),
        .comp         (comp),
        .full         (full),
        .disp_valid   (disp_valid),
        .disp_res     (disp_res),
        .retire_valid (retire_valid),
        .ret          (ret)
    );

    always #2 clk = ~clk;

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    task automatic drive(logic d, dispatch_req_t req, logic c, complete_t cp);
        @(posedge clk);
        #1;
        dispatch = d;
        disp_req = req;
        complete = c;
        comp     = cp;
    endtask

    function automatic dispatch_req_t make_req(int a, int b, int d);
        return '{rs1: 5'(a), rs2: 5'(b), rd: 5'(d)};
    endfunction

    function automatic complete_t make_comp(rob_tag_t t);
        return '{tag: t, value: $urandom()};
    endfunction

    // Picks a random allocated entry that has not completed yet and is not
    // already being completed by the inputs that wait for the next edge.
    function automatic logic pick_pending(output rob_tag_t t);
        int cand [$];
        int idx;
        t = '0;
        for (int i = 0; i < m_count; i++) begin
            idx = (m_head + i) % rob_depth;
            if (!m_done[idx] && !(complete && comp.tag == rob_tag_t'(idx + 1))) begin
                cand.push_back(idx);
            end
        end
        if (cand.size() == 0) begin
            return 1'b0;
        end
        t = rob_tag_t'(cand[$urandom_range(0, cand.size() - 1)] + 1);
        return 1'b1;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            model_step(dispatch, disp_req, complete, comp);
        end
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles", cycles));
        end
    end

    always @(negedge clk) begin
        assert (full === (m_count == rob_depth)) else
            abort_run($sformatf("ERROR at %0t: full is %b", $time, full));
        if (disp_valid !== 1'b0) begin
            assert (exp_disp.size() > 0) else
                abort_run($sformatf("A dispatch result appeared at %0t without a dispatch", $time));
            assert (disp_res === exp_disp[0]) else
                abort_run($sformatf("ERROR at %0t: dispatch result %h, expected %h",
                                    $time, disp_res, exp_disp[0]));
            void'(exp_disp.pop_front());
        end
        if (retire_valid !== 1'b0) begin
            assert (exp_ret.size() > 0) else
                abort_run($sformatf("A retirement appeared at %0t with nothing to retire", $time));
            assert (ret === exp_ret[0]) else
                abort_run($sformatf("ERROR at %0t: retirement %h, expected %h",
                                    $time, ret, exp_ret[0]));
            void'(exp_ret.pop_front());
        end
    end

    initial begin
        rob_tag_t t;
        logic     have;
        void'($urandom(32'h70e28b2e));
        model_reset();
        rst      = 1'b0;
        dispatch = 1'b0;
        disp_req = '0;
        complete = 1'b0;
        comp     = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        // Every register reads zero with tag 0 after reset, register 0 included.
        for (int i = 0; i < 32; i++) begin
            t = rob_tag_t'(m_tail + 1);
            drive(1'b1, make_req(i, 31 - i, 0), 1'b0, '0);
            drive(1'b0, '0, 1'b1, make_comp(t));
        end

        // Seven renames of one register fill the buffer.
        for (int i = 0; i < rob_depth; i++) begin
            drive(1'b1, make_req(5, 0, 5), 1'b0, '0);
        end
        repeat (3) drive(1'b1, make_req(1, 2, 3), 1'b0, '0);
        assert (full === 1'b1) else
            abort_run($sformatf("ERROR at %0t: full is low with seven entries outstanding", $time));

        // Complete youngest first; retirement still follows allocation order.
        for (int i = rob_depth - 1; i >= 0; i--) begin
            drive(1'b0, '0, 1'b1, make_comp(rob_tag_t'((m_head + i) % rob_depth + 1)));
        end
        drive(1'b0, '0, 1'b0, '0);
        drive(1'b1, make_req(5, 0, 0), 1'b0, '0);

        for (int n = 0; n < num_ops; n++) begin
            have = pick_pending(t);
            have = have && ($urandom_range(0, 99) < 45);
            drive($urandom_range(0, 99) < 60,
                  make_req($urandom_range(0, 9), $urandom_range(0, 9), $urandom_range(0, 9)),
                  have, make_comp(t));
        end

        while (m_count != 0) begin
            have = pick_pending(t);
            drive(1'b0, '0, have, make_comp(t));
        end
        repeat (3) drive(1'b0, '0, 1'b0, '0);

        if (exp_disp.size() != 0 || exp_ret.size() != 0) begin
            abort_run("Some expected dispatch results or retirements never appeared");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* sim.f */
+incdir+test
common/ooo_pkg.sv
regfile/reg_file.sv
rob/reorder_buffer.sv
hdl/dispatch_unit.sv
hdl/ooo_front_top.sv
test/tb_ooo_front.sv
